/* sim/golden_stream.txt */
// Each line holds the instruction word, a dependent flag, the expected stall count
// and the expected destination register in hex. A flag of 1 forbids an idle gap before it
// Independent setup
3C081000 0 0 08
34090004 0 0 09
34100010 0 0 10
// Load feeding a branch or jr in decode
8D0A0000 0 0 0a
11400004 1 1 00
8D0B0004 0 0 0b
112B0008 1 1 00
8D1F0008 0 0 1f
03E00008 1 1 00
// Load feeding addu, ori and store data
8D0C000C 0 0 0c
01896821 1 0 0d
8D110010 0 0 11
363200FF 1 0 12
8D0A0014 0 0 0a
AD0A0018 1 0 00
// CALC writer feeding beq and jr
01305821 0 0 0b
11690002 1 0 00
01A9F823 0 0 1f
03E00008 1 0 00
// Writes to register 0
8D000000 0 0 00
10000001 1 0 00
01300021 0 0 00
00000000 1 0 00
// Link write, lui, and a chain behind a held branch
0C000040 0 0 1f
3C0CABCD 1 0 0c
8D10001C 0 0 10
12100003 1 1 00
02000008 1 0 00
36110001 1 0 11

/* list.f */
src/hazardPkg.sv
src/ctrlDecode.sv
src/stallUnit.sv
src/instrFetch.sv
src/stageTrack.sv
src/hazardPipe.sv
sim/hazardPipeTb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       ?= hazardPipeTb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := Simulation FAILED
PASS_MSG  := Simulation PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Test failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "No result found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim/hazardPipeTb.sv */
`timescale 1ns/1ps
`default_nettype none

module hazardPipeTb
    import hazardPkg::*;
();

    localparam int PipeStallW  = 8;
    localparam int MaxWords    = 64;
    localparam int MemDepth    = 4 * MaxWords;
    localparam int ResetCycles = 16;
    localparam int WaitLimit   = 50;

    logic   clk;
    logic   rst_i;
    logic   instrReq_i;
    instrT  instrData_i;
    logic   instrAck_o;
    retireT retire_o;
    logic   retireValid_o;
    logic   stall_o;

    hazardPipe #(
        .PIPE_STALL_W (PipeStallW)
    ) dut (
        .clk           (clk),
        .rst_i         (rst_i),
        .instrReq_i    (instrReq_i),
        .instrData_i   (instrData_i),
        .instrAck_o    (instrAck_o),
        .retire_o      (retire_o),
        .retireValid_o (retireValid_o),
        .stall_o       (stall_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //////////////////////////////
    // Golden stream
    //////////////////////////////

    logic [31:0] goldenMem  [MemDepth];
    instrT       goldWord   [MaxWords];
    logic        goldDep    [MaxWords];
    int          goldStalls [MaxWords];
    regAddrT     goldDst    [MaxWords];
    int          numWords;

    // Monitor side
    int   stallSeen [MaxWords] = '{default: 0};
    int   valueErrors = 0;
    int   protoErrors = 0;
    int   acceptCount = 0;
    int   retireCount = 0;
    int   stallCycles = 0;
    logic ackPrev     = 1'b0;
    logic reqSampled;

    // Stimulus side
    int          checkErrors;
    int          timeouts;
    logic [31:0] randState;

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Count as the retire field should carry it
    function automatic logic [StallW-1:0] satStalls(input int n);
        int lim;
        lim = 2 ** PipeStallW - 1;
        if (n > lim) begin
            n = lim;
        end
        return n[StallW-1:0];
    endfunction

    task automatic loadGolden();
        // Flag column of unused entries stays above 1
        for (int a = 0; a < MemDepth; a++) begin
            goldenMem[a] = 32'hffff_0000 | a;
        end
        $readmemh("sim/golden_stream.txt", goldenMem);
        numWords = 0;
        while (numWords < MaxWords && goldenMem[4 * numWords + 1] <= 1) begin
            goldWord[numWords]   = goldenMem[4 * numWords];
            goldDep[numWords]    = goldenMem[4 * numWords + 1][0];
            goldStalls[numWords] = int'(goldenMem[4 * numWords + 2]);
            goldDst[numWords]    = goldenMem[4 * numWords + 3][4:0];
            numWords++;
        end
    endtask

    task automatic waitAck(input logic level, output logic ok);
        int n;
        n  = 0;
        ok = 1'b1;
        while (instrAck_o !== level) begin
            @(negedge clk);
            n++;
            if (n > WaitLimit) begin
                $display("Timeout at %0t waiting for instrAck_o to become %0b", $time, level);
                timeouts++;
                ok = 1'b0;
                return;
            end
        end
    endtask

    // One four-phase transaction, entered and left on a falling edge
    task automatic sendWord(input instrT word, input int holdCycles, output logic ok);
        instrData_i = word;
        instrReq_i  = 1'b1;
        waitAck(1'b1, ok);
        if (ok) begin
            // Req stays up a while so an early ack drop shows
            repeat (holdCycles) @(negedge clk);
            instrReq_i = 1'b0;
            waitAck(1'b0, ok);
        end
    endtask

    task automatic waitRetireAll(output logic ok);
        int n;
        int lastCount;
        n         = 0;
        lastCount = retireCount;
        ok        = 1'b1;
        while (retireCount < numWords) begin
            @(posedge clk);
            n = (retireCount != lastCount) ? 0 : n + 1;
            lastCount = retireCount;
            if (n > WaitLimit) begin
                $display("Timeout at %0t waiting for retirement %0d", $time, retireCount);
                timeouts++;
                ok = 1'b0;
                return;
            end
        end
    endtask

    task automatic checkIdle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            assert (instrAck_o == 1'b0) else begin
                checkErrors++;
                $display("Error at %0t: instrAck_o = %0b, expected 0", $time, instrAck_o);
            end
            assert (retireValid_o == 1'b0) else begin
                checkErrors++;
                $display("Error at %0t: retireValid_o = %0b, expected 0",
                         $time, retireValid_o);
            end
            assert (stall_o == 1'b0) else begin
                checkErrors++;
                $display("Error at %0t: stall_o = %0b, expected 0", $time, stall_o);
            end
        end
    endtask

    task automatic checkTotals();
        int expTotal;
        expTotal = 0;
        for (int i = 0; i < numWords; i++) begin
            expTotal += goldStalls[i];
        end
        assert (acceptCount == numWords) else begin
            checkErrors++;
            $display("Error at %0t: accepted words = %0d, expected %0d",
                     $time, acceptCount, numWords);
        end
        assert (stallCycles == expTotal) else begin
            checkErrors++;
            $display("Error at %0t: stall_o cycles = %0d, expected %0d",
                     $time, stallCycles, expTotal);
        end
    endtask

    task automatic checkRetire();
        int k;
        k = retireCount;
        assert (k < numWords) else begin
            protoErrors++;
            $display("Retirement at %0t with no word left in the stream", $time);
        end
        if (k < numWords) begin
            assert (retire_o.instr == goldWord[k]) else begin
                valueErrors++;
                $display("Error at %0t: retire_o.instr = %h, expected %h",
                         $time, retire_o.instr, goldWord[k]);
            end
            assert (retire_o.dst == goldDst[k]) else begin
                valueErrors++;
                $display("Error at %0t: retire_o.dst = %0d, expected %0d",
                         $time, retire_o.dst, goldDst[k]);
            end
            assert (retire_o.stalls == satStalls(goldStalls[k])) else begin
                valueErrors++;
                $display("Error at %0t: retire_o.stalls = %0d, expected %0d",
                         $time, retire_o.stalls, satStalls(goldStalls[k]));
            end
            assert (stallSeen[k] == goldStalls[k]) else begin
                valueErrors++;
                $display("Error at %0t: stall_o cycles of word %0d = %0d, expected %0d",
                         $time, k, stallSeen[k], goldStalls[k]);
            end
        end
        retireCount++;
    endtask

    //////////////////////////////
    // Monitor
    //////////////////////////////

    always @(posedge clk) begin
        reqSampled <= instrReq_i;
    end

    // Ack edges are judged against req at the clock edge that moved ack
    always @(negedge clk) begin
        if (!rst_i) begin
            if (instrAck_o && !ackPrev) begin
                acceptCount++;
                assert (reqSampled) else begin
                    protoErrors++;
                    $display("instrAck_o rose at %0t while instrReq_i was low", $time);
                end
            end
            if (!instrAck_o && ackPrev) begin
                assert (!reqSampled) else begin
                    protoErrors++;
                    $display("instrAck_o fell at %0t before instrReq_i fell", $time);
                end
            end
            ackPrev = instrAck_o;
            // Only the newest accepted word can sit in decode
            if (stall_o) begin
                stallCycles++;
                assert (acceptCount > retireCount) else begin
                    protoErrors++;
                    $display("stall_o high at %0t with nothing in flight", $time);
                end
                if (acceptCount > 0) begin
                    stallSeen[acceptCount - 1]++;
                end
            end
            if (retireValid_o) begin
                checkRetire();
            end
        end
    end

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    initial begin
        logic ok;
        int   gap;
        int   hold;
        rst_i       = 1'b1;
        instrReq_i  = 1'b0;
        instrData_i = '0;
        checkErrors = 0;
        timeouts    = 0;
        randState   = 32'h183a_0da9;
        ok          = 1'b1;
        loadGolden();
        assert (numWords > 0) else begin
            checkErrors++;
            $display("No words read from the golden stream file");
        end

        repeat (ResetCycles) @(posedge clk);
        @(negedge clk);
        rst_i = 1'b0;
        checkIdle(4);

        // Idle gaps only before a word that starts a new group
        for (int i = 0; i < numWords && ok; i++) begin
            if (!goldDep[i]) begin
                randState = lcgNext(randState);
                gap = int'(randState[17:16]);
                repeat (gap) @(negedge clk);
            end
            // Longer req hold only where the next word may be delayed
            hold = 0;
            if (i + 1 >= numWords || !goldDep[i + 1]) begin
                randState = lcgNext(randState);
                hold = int'(randState[17:16]);
            end
            sendWord(goldWord[i], hold, ok);
        end
        if (ok) begin
            waitRetireAll(ok);
        end
        if (ok) begin
            repeat (4) @(negedge clk);
            checkTotals();
        end

        $display("Errors: %0d value, %0d protocol, %0d check, %0d timeouts; %0d of %0d retired",
                 valueErrors, protoErrors, checkErrors, timeouts, retireCount, numWords);
        if (ok && valueErrors == 0 && protoErrors == 0 && checkErrors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src/hazardPipe.sv */
`timescale 1ns/1ps
`default_nettype none

module hazardPipe
    import hazardPkg::*;
#(
    parameter int PIPE_STALL_W = 8
) (
    input  logic   clk,
    input  logic   rst_i,
    input  logic   instrReq_i,
    input  instrT  instrData_i,
    output logic   instrAck_o,
    output retireT retire_o,
    output logic   retireValid_o,
    output logic   stall_o
);

    stageRecT dRec, eRec, mRec;
    logic     stall;

    // Intake owns the D register
    instrFetch uFetch (
        .clk         (clk),
        .rst_i       (rst_i),
        .instrReq_i  (instrReq_i),
        .instrData_i (instrData_i),
        .instrAck_o  (instrAck_o),
        .stall_i     (stall),
        .dRec_o      (dRec)
    );

    stageTrack #(
        .PIPE_STALL_W (PIPE_STALL_W)
    ) uTrack (
        .clk           (clk),
        .rst_i         (rst_i),
        .stall_i       (stall),
        .dRec_i        (dRec),
        .eRec_o        (eRec),
        .mRec_o        (mRec),
        .retire_o      (retire_o),
        .retireValid_o (retireValid_o)
    );

    stallUnit uStall (
        .clk     (clk),
        .dRec_i  (dRec),
        .eRec_i  (eRec),
        .mRec_i  (mRec),
        .stall_o (stall)
    );

    assign stall_o = stall;

endmodule

`default_nettype wire

/* src/stageTrack.sv */
`timescale 1ns/1ps
`default_nettype none

module stageTrack
    import hazardPkg::*;
#(
    parameter int PIPE_STALL_W = 8
) (
    input  logic     clk,
    input  logic     rst_i,
    input  logic     stall_i,
    input  stageRecT dRec_i,
    output stageRecT eRec_o,
    output stageRecT mRec_o,
    output retireT   retire_o,
    output logic     retireValid_o
);

    // Saturation limit for the reported stall count
    localparam int unsigned StallMaxInt = (PIPE_STALL_W >= StallW) ?
        (1 << StallW) - 1 : (1 << PIPE_STALL_W) - 1;
    localparam logic [StallW-1:0] StallMax = StallMaxInt[StallW-1:0];

    instrClassE        dClass;
    logic              dWrites;
    regAddrT           dDst;
    logic [StallW-1:0] dStallsSat;
    stageRecT          eRec, mRec, wRec;

    ctrlDecode uDec (
        .instr_i     (dRec_i.instr),
        .class_o     (dClass),
        .writesReg_o (dWrites)
    );

    // A3 selection
    always_comb begin
        dDst = '0;
        if (dWrites) begin
            case (dClass)
                CALC_R:             dDst = dRec_i.instr[15:11];
                CALC_I, LOAD, LUI:  dDst = dRec_i.instr[20:16];
                JAL:                dDst = regAddrT'(31);
                default:            dDst = '0;
            endcase
        end
    end

    assign dStallsSat = (dRec_i.stalls > StallMax) ? StallMax : dRec_i.stalls;

    //////////////////////////////
    // E, M and W registers
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst_i) begin
            eRec <= '0;
            mRec <= '0;
            wRec <= '0;
        end else begin
            // Bubble into E while decode is held or empty
            if (stall_i || !dRec_i.valid) begin
                eRec <= '0;
            end else begin
                eRec <= '{valid: 1'b1, instr: dRec_i.instr, dst: dDst, stalls: dStallsSat};
            end
            mRec <= eRec;
            wRec <= mRec;
        end
    end

    assign eRec_o = eRec;
    assign mRec_o = mRec;

    // W lasts one cycle, so valid is already a pulse
    assign retire_o      = '{instr: wRec.instr, dst: wRec.dst, stalls: wRec.stalls};
    assign retireValid_o = wRec.valid;

    // Held decode word stays put while E takes the bubble
    aBubbleAfterStall : assert property (@(posedge clk) disable iff (rst_i)
        stall_i |=> !eRec_o.valid && $stable(dRec_i.instr));

endmodule

`default_nettype wire

/* src/instrFetch.sv */
`timescale 1ns/1ps
`default_nettype none

module instrFetch
    import hazardPkg::*;
(
    input  logic     clk,
    input  logic     rst_i,
    input  logic     instrReq_i,
    input  instrT    instrData_i,
    output logic     instrAck_o,
    input  logic     stall_i,
    output stageRecT dRec_o
);

    typedef enum logic {
        IDLE,
        ACK_HIGH
    } linkStateE;

    linkStateE         linkState;
    logic              dValid;
    instrT             dInstr;
    logic [StallW-1:0] dStalls;
    logic              dFree;
    logic              take;

    // Slot is free if empty or moving on to E this cycle
    assign dFree = !dValid || !stall_i;
    assign take  = (linkState == IDLE) && instrReq_i && dFree;

    //////////////////////////////
    // Four-phase link
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst_i) begin
            linkState <= IDLE;
        end else begin
            case (linkState)
                IDLE: begin
                    if (take) begin
                        linkState <= ACK_HIGH;
                    end
                end
                // Hold ack until the source drops req
                ACK_HIGH: begin
                    if (!instrReq_i) begin
                        linkState <= IDLE;
                    end
                end
                default: linkState <= IDLE;
            endcase
        end
    end

    assign instrAck_o = (linkState == ACK_HIGH);

    //////////////////////////////
    // Decode stage register
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst_i) begin
            dValid <= 1'b0;
        end else if (take) begin
            dValid <= 1'b1;
        end else if (!stall_i) begin
            dValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            dInstr  <= instrData_i;
            dStalls <= '0;
        end else if (dValid && stall_i && (dStalls != '1)) begin
            // Saturating count of held cycles
            dStalls <= dStalls + 1'b1;
        end
    end

    // Destination is resolved later, on entry to E
    assign dRec_o = '{valid: dValid, instr: dInstr, dst: regAddrT'(0), stalls: dStalls};

    aAckNeedsReq : assert property (@(posedge clk) disable iff (rst_i)
        $rose(instrAck_o) |-> $past(instrReq_i));

endmodule

`default_nettype wire

/* src/stallUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module stallUnit
    import hazardPkg::*;
(
    input  logic     clk,
    input  stageRecT dRec_i,
    input  stageRecT eRec_i,
    input  stageRecT mRec_i,
    output logic     stall_o
);

    localparam int StD = 0;
    localparam int StE = 1;
    localparam int StM = 2;

    stageRecT   recs     [DecodeStages];
    instrClassE classes  [DecodeStages];
    logic       writes   [DecodeStages];

    assign recs[StD] = dRec_i;
    assign recs[StE] = eRec_i;
    assign recs[StM] = mRec_i;

    // One decoder per observed stage
    for (genvar g = 0; g < DecodeStages; g++) begin : gDec
        ctrlDecode uDec (
            .instr_i     (recs[g].instr),
            .class_o     (classes[g]),
            .writesReg_o (writes[g])
        );
    end

    //////////////////////////////
    // Use and ready times
    //////////////////////////////

    logic [1:0] tUseRs, tUseRt, tNewE, tNewM;

    always_comb begin
        case (classes[StD])
            BRANCH, JR, LUI:               tUseRs = 2'd0;
            CALC_R, CALC_I, LOAD, STORE:   tUseRs = 2'd1;
            default:                       tUseRs = 2'd3;
        endcase

        case (classes[StD])
            BRANCH, LUI: tUseRt = 2'd0;
            CALC_R:      tUseRt = 2'd1;
            STORE:       tUseRt = 2'd2;
            default:     tUseRt = 2'd3;
        endcase

        // An empty decode slot reads nothing
        if (!dRec_i.valid) begin
            tUseRs = 2'd3;
            tUseRt = 2'd3;
        end

        case (classes[StE])
            CALC_R, CALC_I: tNewE = 2'd1;
            LOAD:           tNewE = 2'd2;
            default:        tNewE = 2'd0;
        endcase

        tNewM = (classes[StM] == LOAD) ? 2'd1 : 2'd0;
    end

    //////////////////////////////
    // Stall decision
    //////////////////////////////

    regAddrT dRs, dRt;
    logic    eLive, mLive;
    logic    stallRs, stallRt;

    assign dRs = dRec_i.instr[25:21];
    assign dRt = dRec_i.instr[20:16];

    // A stage only matters if it will write a real register
    assign eLive = eRec_i.valid && writes[StE] && (eRec_i.dst != '0);
    assign mLive = mRec_i.valid && writes[StM] && (mRec_i.dst != '0);

    assign stallRs = (eLive && (dRs == eRec_i.dst) && (tNewE > tUseRs)) ||
                     (mLive && (dRs == mRec_i.dst) && (tNewM > tUseRs));
    assign stallRt = (eLive && (dRt == eRec_i.dst) && (tNewE > tUseRt)) ||
                     (mLive && (dRt == mRec_i.dst) && (tNewM > tUseRt));

    assign stall_o = stallRs || stallRt;

    // Nothing to hold when decode is empty
    aStallNeedsD : assert property (@(posedge clk) stall_o |-> dRec_i.valid);

endmodule

`default_nettype wire

/* src/ctrlDecode.sv */
`timescale 1ns/1ps
`default_nettype none

module ctrlDecode
    import hazardPkg::*;
(
    input  instrT      instr_i,
    output instrClassE class_o,
    output logic       writesReg_o
);

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = instr_i[31:26];
    assign funct  = instr_i[5:0];

    always_comb begin
        // Anything not recognised is treated as a nop
        class_o     = NOP;
        writesReg_o = 1'b0;

        case (opcode)
            OP_SPECIAL: begin
                case (funct)
                    FN_ADDU, FN_SUBU: begin
                        class_o     = CALC_R;
                        writesReg_o = 1'b1;
                    end
                    FN_JR: begin
                        class_o = JR;
                    end
                    // Includes the all-zero word (sll $0,$0,0)
                    default: begin
                        class_o = NOP;
                    end
                endcase
            end
            OP_ORI: begin
                class_o     = CALC_I;
                writesReg_o = 1'b1;
            end
            OP_LUI: begin
                class_o     = LUI;
                writesReg_o = 1'b1;
            end
            OP_LW: begin
                class_o     = LOAD;
                writesReg_o = 1'b1;
            end
            OP_SW: begin
                class_o = STORE;
            end
            OP_BEQ: begin
                class_o = BRANCH;
            end
            // Link register write
            OP_JAL: begin
                class_o     = JAL;
                writesReg_o = 1'b1;
            end
            default: begin
                class_o     = NOP;
                writesReg_o = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* src/hazardPkg.sv */
`default_nettype none

package hazardPkg;

    //////////////////////////////
    // Basic word types
    //////////////////////////////

    typedef logic [31:0] instrT;
    typedef logic [4:0]  regAddrT;

    // Width of the stall count carried in each stage record
    localparam int StallW = 8;

    // Decoder copies inside the stall unit, one each for D, E and M
    localparam int DecodeStages = 3;

    //////////////////////////////
    // MIPS encodings
    //////////////////////////////

    // Primary opcode field, instr[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcodeE;

    // Function field for OP_SPECIAL, instr[5:0]
    typedef enum logic [5:0] {
        FN_JR   = 6'h08,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23
    } functE;

    // Instruction classes seen by the hazard logic
    typedef enum logic [3:0] {
        CALC_R,
        CALC_I,
        LUI,
        LOAD,
        STORE,
        BRANCH,
        JAL,
        JR,
        NOP
    } instrClassE;

    //////////////////////////////
    // Stage and retire records
    //////////////////////////////

    typedef struct packed {
        logic              valid;
        instrT             instr;
        regAddrT           dst;     // A3, register written at W
        logic [StallW-1:0] stalls;  // Cycles held in decode
    } stageRecT;

    typedef struct packed {
        instrT             instr;
        regAddrT           dst;
        logic [StallW-1:0] stalls;
    } retireT;

endpackage

`default_nettype wire
